// File: flist.f
+incdir+logic
logic/spi_cfg_pkg.sv
logic/spi_ctrl_pkg.sv
logic/spi_host_buffers.sv
logic/spi_bit_clock.sv
logic/spi_shifter.sv
logic/spi_master.sv
tests/spi_master_properties.sv
tests/spi_master_tb.sv

// File: logic/spi_bit_clock.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_bit_clock (
    input  logic                       wr,         // System clock.
    input  logic                       rst_n,      // Async reset, active low.
    input  logic                       start,      // Frame start, latches the code.
    input  logic                       run,        // High while a frame is active.
    input  logic [`SPI_PRESCALE_W-1:0] prescale,   // Divider code from the buffer.
    output logic                       half_tick   // One pulse per SCK half-period.
);

    // Two in counter width. Shifted by the code it gives 2^(code+1).
    localparam logic [`SPI_DIV_CNT_W-1:0] div_two = 2;

    logic [`SPI_PRESCALE_W-1:0] presc_q;    // Code held for the whole frame.
    logic [`SPI_DIV_CNT_W-1:0]  div_cnt;    // Cycles spent in this half-period.
    logic [`SPI_DIV_CNT_W-1:0]  div_limit;  // Last count of a half-period.

    // For code 7 the shift wraps to zero and the subtraction gives 255.
    assign div_limit = (div_two << presc_q) - 1'b1;
    assign half_tick = run && (div_cnt == div_limit);

    always_ff @(posedge wr or negedge rst_n) begin
        if (!rst_n) begin
            presc_q <= '0;
            div_cnt <= '0;
        end else if (start) begin
            presc_q <= prescale;  // Taken once per frame.
            div_cnt <= '0;
        end else if (run) begin
            if (div_cnt == div_limit) begin
                div_cnt <= '0;  // Half-period ends here.
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

// File: logic/spi_cfg_pkg.sv
package spi_cfg_pkg;

    // SPI mode as seen by the host.
    // Bit 1 is CPOL, the idle level of SCK.
    // Bit 0 is CPHA. When it is 0 the slave samples on the first edge of a bit,
    // when it is 1 it samples on the second edge.
    typedef enum logic [1:0] {
        MODE0 = 2'b00,  // CPOL 0, CPHA 0.
        MODE1 = 2'b01,  // CPOL 0, CPHA 1.
        MODE2 = 2'b10,  // CPOL 1, CPHA 0.
        MODE3 = 2'b11   // CPOL 1, CPHA 1.
    } spi_mode_e;

endpackage

// File: logic/spi_consts.svh
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// Bits carried in one SPI frame.
`define SPI_WORD_LEN   8
// Width of the host prescale code.
`define SPI_PRESCALE_W 3
// Prescaler counter, wide enough for 256 counts.
`define SPI_DIV_CNT_W  8
// Half-period counter, counts up to 16 half-periods of SCK.
`define SPI_BIT_CNT_W  5

`endif

// File: logic/spi_ctrl_pkg.sv
package spi_ctrl_pkg;

    // Frame state of the shifter.
    typedef enum logic {
        IDLE = 1'b0,  // Waiting for a word in the transmit buffer.
        BUSY = 1'b1   // A frame is on the wire.
    } shifter_state_e;

endpackage

// File: logic/spi_host_buffers.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_host_buffers (
    input  logic                          wr,             // System clock.
    input  logic                          rst_n,          // Async reset, active low.
    input  logic                          load,           // One-cycle load strobe.
    input  logic [`SPI_WORD_LEN-1:0]      tx_data,        // Word to send.
    input  spi_cfg_pkg::spi_mode_e        mode,           // SPI mode for this word.
    input  logic                          lsb_first,      // Bit order for this word.
    input  logic [`SPI_PRESCALE_W-1:0]    prescale,       // SCK divider code.
    input  logic                          err_clr,        // Clears the sticky send error.
    input  logic                          take,           // Shifter takes the buffered word.
    input  logic                          frame_done,     // Shifter finished a frame.
    input  logic [`SPI_WORD_LEN-1:0]      rx_word,        // Word received in that frame.
    input  logic                          rd,             // One-cycle read strobe.
    output logic                          buf_full,
    output logic [`SPI_WORD_LEN-1:0]      buf_data,
    output spi_cfg_pkg::spi_mode_e        buf_mode,
    output logic                          buf_lsb_first,
    output logic [`SPI_PRESCALE_W-1:0]    buf_prescale,
    output logic                          tx_empty,
    output logic                          send_err,
    output logic [`SPI_WORD_LEN-1:0]      rx_data,
    output logic                          char_received
);
    import spi_cfg_pkg::*;

    logic load_ok;   // Load lands in an empty buffer.
    logic load_bad;  // Load hits a full buffer.

    assign load_ok  = load && !buf_full;
    assign load_bad = load && buf_full;
    assign tx_empty = ~buf_full;  // The host polls this before loading.

    //////////////////////////////
    // Transmit side
    //////////////////////////////

    // Full flag and the transfer settings that travel with the word.
    always_ff @(posedge wr or negedge rst_n) begin
        if (!rst_n) begin
            buf_full      <= 1'b0;
            buf_mode      <= MODE0;  // Keeps SCK low out of reset.
            buf_lsb_first <= 1'b0;
            buf_prescale  <= '0;
        end else begin
            if (take) begin
                buf_full <= 1'b0;  // Shifter copied the word on this edge.
            end else if (load_ok) begin
                buf_full      <= 1'b1;
                buf_mode      <= mode;
                buf_lsb_first <= lsb_first;
                buf_prescale  <= prescale;
            end
        end
    end

    // Data word itself. A rejected load leaves it untouched.
    always_ff @(posedge wr) begin
        if (load_ok) begin
            buf_data <= tx_data;
        end
    end

    // Sticky error. A clear wins over a new error in the same cycle.
    always_ff @(posedge wr or negedge rst_n) begin
        if (!rst_n) begin
            send_err <= 1'b0;
        end else if (err_clr) begin
            send_err <= 1'b0;
        end else if (load_bad) begin
            send_err <= 1'b1;
        end
    end

    //////////////////////////////
    // Receive side
    //////////////////////////////

    // The newest word always replaces the old one, read or not.
    always_ff @(posedge wr) begin
        if (frame_done) begin
            rx_data <= rx_word;
        end
    end

    // A completed frame beats a read strobe in the same cycle.
    always_ff @(posedge wr or negedge rst_n) begin
        if (!rst_n) begin
            char_received <= 1'b0;
        end else if (frame_done) begin
            char_received <= 1'b1;
        end else if (rd) begin
            char_received <= 1'b0;
        end
    end

endmodule

// File: logic/spi_master.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_master (
    input  logic                       wr,             // System clock.
    input  logic                       rst_n,          // Async reset, active low.
    input  logic                       load,           // Host load strobe.
    input  logic [`SPI_WORD_LEN-1:0]   tx_data,
    input  spi_cfg_pkg::spi_mode_e     mode,
    input  logic                       lsb_first,
    input  logic [`SPI_PRESCALE_W-1:0] prescale,
    input  logic                       err_clr,
    input  logic                       rd,             // Host read strobe.
    input  logic                       miso,
    output logic                       tx_empty,
    output logic                       send_err,
    output logic [`SPI_WORD_LEN-1:0]   rx_data,
    output logic                       char_received,
    output logic                       sck,
    output logic                       mosi,
    output logic                       ss
);
    import spi_cfg_pkg::*;

    // Buffer to shifter.
    logic                       buf_full;
    logic [`SPI_WORD_LEN-1:0]   buf_data;
    spi_mode_e                  buf_mode;
    logic                       buf_lsb_first;
    logic [`SPI_PRESCALE_W-1:0] buf_prescale;  // Goes to the bit clock.
    // Shifter back to the buffer and bit clock.
    logic                       take;
    logic                       start;
    logic                       run;
    logic                       frame_done;
    logic [`SPI_WORD_LEN-1:0]   rx_word;
    logic                       half_tick;     // Bit clock to shifter.

    spi_host_buffers u_buffers (
        .wr, .rst_n, .load, .tx_data, .mode, .lsb_first, .prescale, .err_clr,
        .take, .frame_done, .rx_word, .rd,
        .buf_full, .buf_data, .buf_mode, .buf_lsb_first, .buf_prescale,
        .tx_empty, .send_err, .rx_data, .char_received
    );

    spi_bit_clock u_bit_clock (
        .wr, .rst_n, .start, .run,
        .prescale  (buf_prescale),
        .half_tick
    );

    spi_shifter u_shifter (
        .wr, .rst_n, .buf_full, .buf_data, .buf_mode, .buf_lsb_first,
        .half_tick, .miso,
        .take, .start, .run, .frame_done, .rx_word,
        .sck, .mosi, .ss
    );

endmodule

// File: logic/spi_shifter.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_shifter (
    input  logic                      wr,             // System clock.
    input  logic                      rst_n,          // Async reset, active low.
    input  logic                      buf_full,       // A word waits in the buffer.
    input  logic [`SPI_WORD_LEN-1:0]  buf_data,       // That word.
    input  spi_cfg_pkg::spi_mode_e    buf_mode,       // Its SPI mode.
    input  logic                      buf_lsb_first,  // Its bit order.
    input  logic                      half_tick,      // SCK half-period boundary.
    input  logic                      miso,           // Serial data from the slave.
    output logic                      take,           // Empties the buffer.
    output logic                      start,          // Restarts the bit clock.
    output logic                      run,            // Bit clock enable.
    output logic                      frame_done,     // Last half-tick of a frame.
    output logic [`SPI_WORD_LEN-1:0]  rx_word,        // Word received in the frame.
    output logic                      sck,
    output logic                      mosi,
    output logic                      ss
);
    import spi_cfg_pkg::*;
    import spi_ctrl_pkg::*;

    // Half-tick count at which a frame of two edges per bit ends.
    localparam logic [`SPI_BIT_CNT_W-1:0] last_half = 2 * `SPI_WORD_LEN - 1;

    shifter_state_e              state;
    spi_mode_e                   mode_q;     // Mode latched at frame start.
    logic                        lsb_q;      // Bit order latched at frame start.
    logic [`SPI_BIT_CNT_W-1:0]   half_cnt;   // Half-periods done in this frame.
    logic                        sck_phase;  // SCK before polarity is applied.
    logic [`SPI_WORD_LEN-1:0]    tx_sr;      // Outgoing bits, current one at the edge.
    logic [`SPI_WORD_LEN-1:0]    rx_sr;      // Incoming bits.
    logic [`SPI_WORD_LEN-1:0]    rx_shift;   // rx_sr with the MISO bit shifted in.
    logic                        sample_now; // This half-tick samples MISO.
    logic                        shift_now;  // This half-tick moves to the next bit.
    logic                        last_tick;  // This half-tick closes the frame.

    //////////////////////////////
    // Handshake with the buffer and bit clock
    //////////////////////////////

    assign take  = (state == IDLE) && buf_full;  // Same edge starts the frame.
    assign start = take;
    assign run   = (state == BUSY);

    // With CPHA 0 the odd half-ticks sample, with CPHA 1 the even ones do.
    assign sample_now = (half_cnt[0] == mode_q[0]);
    // The first half-tick never shifts, the first bit is already on MOSI.
    assign shift_now  = !sample_now && (half_cnt != '0);
    assign last_tick  = (half_cnt == last_half);
    assign frame_done = run && half_tick && last_tick;

    // New MISO bit enters at the LSB for MSB-first, at the MSB for LSB-first.
    assign rx_shift = lsb_q ? {miso, rx_sr[`SPI_WORD_LEN-1:1]}
                            : {rx_sr[`SPI_WORD_LEN-2:0], miso};
    // With CPHA 1 the last sample falls on the closing half-tick itself.
    assign rx_word  = sample_now ? rx_shift : rx_sr;

    //////////////////////////////
    // Frame FSM and counters
    //////////////////////////////

    always_ff @(posedge wr or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            ss        <= 1'b1;
            mode_q    <= MODE0;  // SCK idles low after reset.
            lsb_q     <= 1'b0;
            half_cnt  <= '0;
            sck_phase <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (buf_full) begin
                        state     <= BUSY;
                        ss        <= 1'b0;  // Already low when words run back to back.
                        mode_q    <= buf_mode;
                        lsb_q     <= buf_lsb_first;
                        half_cnt  <= '0;
                        sck_phase <= 1'b0;
                    end
                end
                BUSY: begin
                    if (half_tick) begin
                        if (last_tick) begin
                            state     <= IDLE;
                            half_cnt  <= '0;
                            sck_phase <= 1'b0;  // Back to the idle level.
                            // SS stays low if another word is waiting.
                            if (!buf_full) begin
                                ss <= 1'b1;
                            end
                        end else begin
                            half_cnt  <= half_cnt + 1'b1;
                            sck_phase <= ~sck_phase;  // One SCK edge per half-tick.
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Data path
    //////////////////////////////

    // Shift registers. Vacated transmit bits fill with ones.
    always_ff @(posedge wr) begin
        if (take) begin
            tx_sr <= buf_data;
        end else if (run && half_tick) begin
            if (sample_now) begin
                rx_sr <= rx_shift;
            end else if (shift_now) begin
                if (lsb_q) begin
                    tx_sr <= {1'b1, tx_sr[`SPI_WORD_LEN-1:1]};
                end else begin
                    tx_sr <= {tx_sr[`SPI_WORD_LEN-2:0], 1'b1};
                end
            end
        end
    end

    // CPOL inverts the internal phase.
    assign sck  = sck_phase ^ mode_q[1];
    // MOSI idles high while the slave is not selected.
    assign mosi = ss ? 1'b1 : (lsb_q ? tx_sr[0] : tx_sr[`SPI_WORD_LEN-1]);

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the SPI master testbench with Verilator and runs it.
# A failed build or a failed simulation gives a nonzero exit status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module spi_master_tb -f flist.f -o spi_master_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status."
    exit "$status"
fi

./obj_dir/spi_master_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status."
    exit "$status"
fi

exit 0

// File: tests/spi_master_properties.sv
`timescale 1ns/1ps

module spi_master_properties (
    input logic                         wr,        // System clock.
    input logic                         rst_n,     // Async reset, active low.
    input logic                         ss,
    input logic                         sck,
    input logic                         mosi,
    input logic                         send_err,
    input logic                         err_clr,
    input spi_cfg_pkg::spi_mode_e       mode_q,    // Mode latched by the shifter.
    input spi_ctrl_pkg::shifter_state_e state      // Shifter FSM state.
);
    import spi_ctrl_pkg::*;

    // A deselected bus sits at the idle SCK level with MOSI high.
    idle_bus_levels: assert property (@(posedge wr) disable iff (!rst_n)
        ss |-> (sck == mode_q[1]) && mosi)
        else $error("SCK or MOSI is off its idle level while SS is high.");

    // The send error is sticky until the host clears it.
    send_err_sticky: assert property (@(posedge wr) disable iff (!rst_n)
        $fell(send_err) |-> $past(err_clr))
        else $error("send_err fell without err_clr.");

    // No frame can be running once SS has stayed high for a whole cycle.
    idle_when_deselected: assert property (@(posedge wr) disable iff (!rst_n)
        ss && $past(ss) |-> state == IDLE)
        else $error("Shifter is not idle while SS is high.");

endmodule

// Internal shifter signals are picked up in the scope of the top level.
bind spi_master spi_master_properties u_properties (
    .wr,
    .rst_n,
    .ss,
    .sck,
    .mosi,
    .send_err,
    .err_clr,
    .mode_q (u_shifter.mode_q),
    .state  (u_shifter.state)
);

// File: tests/spi_master_tb.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_master_tb;
    import spi_cfg_pkg::*;

    // Each frame is 16 half-periods of 2^(code+1) cycles. Terms follow the test order.
    localparam int timeout_cycles =
        16 * (4 * 4 + 2 * 4 + (2 + 8 + 64) + 3 * (2 * 2)) + 400;
    localparam int frame_edges = 2 * `SPI_WORD_LEN;  // SCK edges in one word.

    logic                       wr;
    logic                       rst_n;
    logic                       load;
    logic [`SPI_WORD_LEN-1:0]   tx_data;
    spi_mode_e                  mode;
    logic                       lsb_first;
    logic [`SPI_PRESCALE_W-1:0] prescale;
    logic                       err_clr;
    logic                       rd;
    logic                       miso = 1'b0;  // Owned by the slave model.
    logic                       tx_empty;
    logic                       send_err;
    logic [`SPI_WORD_LEN-1:0]   rx_data;
    logic                       char_received;
    logic                       sck;
    logic                       mosi;
    logic                       ss;

    logic [31:0] lfsr = 32'hd7ea2741;  // Galois LFSR state.
    int          cycle_cnt = 0;        // Cycles since time zero.

    // Slave model state. Replies are queued per frame, received words collected.
    spi_mode_e                slave_mode = MODE0;
    logic                     slave_lsb = 1'b0;
    logic [`SPI_WORD_LEN-1:0] reply_q[$];
    logic [`SPI_WORD_LEN-1:0] got_q[$];
    logic                     slave_active = 1'b0;  // Inside a word.
    int                       edge_cnt;             // SCK edges seen in this word.
    int                       slave_bit;
    logic [`SPI_WORD_LEN-1:0] slave_tx;
    logic [`SPI_WORD_LEN-1:0] slave_rx;
    logic                     sck_prev;
    logic                     mosi_prev;  // MOSI just before the current edge.

    spi_master dut (
        .wr, .rst_n, .load, .tx_data, .mode, .lsb_first, .prescale, .err_clr, .rd, .miso,
        .tx_empty, .send_err, .rx_data, .char_received, .sck, .mosi, .ss
    );

    always #10 wr = ~wr;  // 20 ns period.

    always @(posedge wr) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_cycles) begin
            fail_run("Run went past its cycle limit before the tests finished.");
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
            else fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);  // Right-shift Galois form.
    endfunction

    function automatic logic [`SPI_WORD_LEN-1:0] random_word();
        logic [`SPI_WORD_LEN-1:0] w;
        w = '0;
        for (int i = 0; i < `SPI_WORD_LEN; i++) begin
            w    = {w[`SPI_WORD_LEN-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);  // One step per bit taken.
        end
        return w;
    endfunction

    // Bit k of a word in wire order.
    function automatic logic word_bit(input logic [`SPI_WORD_LEN-1:0] w, input int k,
                                      input logic lsb);
        return lsb ? w[k] : w[`SPI_WORD_LEN-1-k];
    endfunction

    task automatic step();
        @(posedge wr);
        #2;  // Drive and sample away from the edge.
    endtask

    task automatic send_word(input logic [`SPI_WORD_LEN-1:0] data, input spi_mode_e m,
                             input logic lsb, input logic [`SPI_PRESCALE_W-1:0] presc);
        slave_mode = m;
        slave_lsb  = lsb;
        tx_data    = data;
        mode       = m;
        lsb_first  = lsb;
        prescale   = presc;
        load       = 1'b1;
        step();
        load       = 1'b0;
    endtask

    task automatic wait_received();
        while (!char_received) step();  // The cycle limit guards this loop.
    endtask

    task automatic read_and_clear();
        rd = 1'b1;
        step();
        rd = 1'b0;
        expect_equal("char_received", char_received, 1'b0);
    endtask

    // The slave files a word on the falling edge after the last SCK edge.
    task automatic expect_slave_word(input logic [`SPI_WORD_LEN-1:0] exp);
        assert (got_q.size() != 0)
            else fail_run("The slave model received no word on MOSI.");
        expect_equal("slave word on mosi", got_q.pop_front(), exp);
    endtask

    // One complete word, checked on both wires, then the flag is read back.
    task automatic transfer_one(input spi_mode_e m, input logic lsb,
                                input logic [`SPI_PRESCALE_W-1:0] presc);
        logic [`SPI_WORD_LEN-1:0] word;
        logic [`SPI_WORD_LEN-1:0] reply;
        word  = random_word();
        reply = random_word();
        reply_q.push_back(reply);
        send_word(word, m, lsb, presc);
        wait_received();
        expect_equal("rx_data", rx_data, reply);
        expect_equal("ss", ss, 1'b1);
        expect_equal("sck", sck, m[1]);  // Idle level of this mode.
        read_and_clear();
        expect_slave_word(word);
    endtask

    //////////////////////////////
    // Slave model
    //////////////////////////////

    // Runs on the falling edge of wr, where SCK and MOSI are stable.
    always @(negedge wr) begin
        if (slave_active && (sck != sck_prev)) begin
            edge_cnt = edge_cnt + 1;
            slave_bit = (edge_cnt - 1) / 2;
            // Odd edges lead. CPHA 0 samples on them, CPHA 1 on the trailing ones.
            if ((edge_cnt % 2 == 1) != slave_mode[0]) begin
                slave_rx[slave_lsb ? slave_bit : `SPI_WORD_LEN-1-slave_bit] = mosi_prev;
            end else if (edge_cnt < frame_edges) begin
                miso = word_bit(slave_tx, edge_cnt / 2, slave_lsb);
            end
            if (edge_cnt == frame_edges) begin
                got_q.push_back(slave_rx);
                slave_active = 1'b0;
            end
        end
        if (!slave_active && !ss) begin
            slave_tx     = (reply_q.size() != 0) ? reply_q.pop_front() : '1;
            slave_rx     = '0;
            edge_cnt     = 0;
            slave_active = 1'b1;
            if (!slave_mode[0]) miso = word_bit(slave_tx, 0, slave_lsb);  // CPHA 0 leads.
        end
        if (ss) slave_active = 1'b0;
        sck_prev  = sck;
        mosi_prev = mosi;
    end

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic reset_and_all_modes();
        expect_equal("ss", ss, 1'b1);
        expect_equal("tx_empty", tx_empty, 1'b1);
        expect_equal("mosi", mosi, 1'b1);
        expect_equal("send_err", send_err, 1'b0);
        expect_equal("char_received", char_received, 1'b0);
        expect_equal("sck", sck, 1'b0);
        for (int i = 0; i < 4; i++) transfer_one(spi_mode_e'(i), 1'b0, 3'd1);
    endtask

    task automatic lsb_first_order();
        transfer_one(MODE0, 1'b1, 3'd1);
        transfer_one(MODE3, 1'b1, 3'd1);
    endtask

    task automatic prescaler_periods();
        int   codes[3] = '{0, 2, 5};
        int   n;
        logic last_sck;
        logic [`SPI_WORD_LEN-1:0] word;
        logic [`SPI_WORD_LEN-1:0] reply;
        foreach (codes[c]) begin
            word  = random_word();
            reply = random_word();
            reply_q.push_back(reply);
            send_word(word, MODE0, 1'b0, codes[c][`SPI_PRESCALE_W-1:0]);
            while (ss) step();
            // The first count runs from SS falling, the others between SCK edges.
            for (int h = 0; h < 4; h++) begin
                last_sck = sck;
                n = 0;
                do begin
                    step();
                    n = n + 1;
                end while (sck == last_sck);
                expect_equal("sck half-period in wr cycles", n, 1 << (codes[c] + 1));
            end
            wait_received();
            expect_equal("rx_data", rx_data, reply);
            read_and_clear();
            expect_slave_word(word);
        end
    endtask

    task automatic back_to_back_words();
        logic [`SPI_WORD_LEN-1:0] word_a;
        logic [`SPI_WORD_LEN-1:0] word_b;
        logic [`SPI_WORD_LEN-1:0] reply_a;
        logic [`SPI_WORD_LEN-1:0] reply_b;
        word_a  = random_word();
        word_b  = random_word();
        reply_a = random_word();
        reply_b = random_word();
        reply_q.push_back(reply_a);
        reply_q.push_back(reply_b);
        send_word(word_a, MODE1, 1'b0, 3'd0);
        while (!tx_empty) step();
        send_word(word_b, MODE1, 1'b0, 3'd0);  // Second word queued mid-frame.
        do begin
            step();
            expect_equal("ss", ss, 1'b0);  // Held low across the gap.
        end while (!char_received);
        expect_equal("rx_data", rx_data, reply_a);
        read_and_clear();
        wait_received();
        expect_equal("rx_data", rx_data, reply_b);
        read_and_clear();
        expect_slave_word(word_a);
        expect_slave_word(word_b);
    endtask

    task automatic send_error_flag();
        logic [`SPI_WORD_LEN-1:0] word_a;
        logic [`SPI_WORD_LEN-1:0] word_b;
        logic [`SPI_WORD_LEN-1:0] reply_a;
        logic [`SPI_WORD_LEN-1:0] reply_b;
        word_a  = random_word();
        word_b  = random_word();
        reply_a = random_word();
        reply_b = random_word();
        reply_q.push_back(reply_a);
        reply_q.push_back(reply_b);
        send_word(word_a, MODE2, 1'b0, 3'd0);
        while (!tx_empty) step();
        send_word(word_b, MODE2, 1'b0, 3'd0);
        expect_equal("tx_empty", tx_empty, 1'b0);
        send_word(~word_b, MODE2, 1'b0, 3'd0);  // Buffer is full, so this is refused.
        expect_equal("send_err", send_err, 1'b1);
        expect_equal("buf_data", dut.u_buffers.buf_data, word_b);
        repeat (3) step();
        expect_equal("send_err", send_err, 1'b1);
        err_clr = 1'b1;
        step();
        err_clr = 1'b0;
        expect_equal("send_err", send_err, 1'b0);
        wait_received();
        expect_equal("rx_data", rx_data, reply_a);
        read_and_clear();
        wait_received();
        expect_equal("rx_data", rx_data, reply_b);
        read_and_clear();
        expect_slave_word(word_a);
        expect_slave_word(word_b);  // The refused word never reached the wire.
    endtask

    task automatic received_flag_rules();
        logic [`SPI_WORD_LEN-1:0] word_a;
        logic [`SPI_WORD_LEN-1:0] reply_a;
        logic [`SPI_WORD_LEN-1:0] word_b;
        logic [`SPI_WORD_LEN-1:0] reply_b;
        word_a  = random_word();
        reply_a = random_word();
        reply_q.push_back(reply_a);
        send_word(word_a, MODE0, 1'b0, 3'd0);
        wait_received();
        expect_equal("rx_data", rx_data, reply_a);
        // Second word without a read in between.
        word_b  = random_word();
        reply_b = random_word();
        reply_q.push_back(reply_b);
        send_word(word_b, MODE0, 1'b0, 3'd0);
        expect_slave_word(word_a);
        while (ss) step();
        while (!ss) step();  // SS rises on the edge that stores the word.
        expect_equal("char_received", char_received, 1'b1);
        expect_equal("rx_data", rx_data, reply_b);
        read_and_clear();
        expect_slave_word(word_b);
    endtask

    initial begin
        wr        = 1'b0;
        rst_n     = 1'b0;
        load      = 1'b0;
        tx_data   = '0;
        mode      = MODE0;
        lsb_first = 1'b0;
        prescale  = '0;
        err_clr   = 1'b0;
        rd        = 1'b0;
        repeat (8) @(posedge wr);
        #2;
        rst_n = 1'b1;
        step();
        reset_and_all_modes();
        lsb_first_order();
        prescaler_periods();
        back_to_back_words();
        send_error_flag();
        received_flag_rules();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
